// ==== backend.f ====
+incdir+hw
hw/backend_pkg.sv
hw/arch_regfile.sv
hw/dispatch.sv
hw/issue_queue.sv
hw/alu_unit.sv
hw/shift_unit.sv
hw/writeback_arbiter.sv
hw/reorder_buffer.sv
hw/backend_top.sv
testbench/clock_gen.sv
testbench/backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f backend.f \
	--top-module backend_tb -o backend_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/backend_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
	exit 0
fi
echo "simulation did not report a clean run"
exit 1

// ==== testbench/backend_tb.sv ====
// drives at posedge + 2 ns and samples at negedge; expects in-order commits after a flush restart
`timescale 1ns/1ns
`default_nettype none

`include "backend_cfg.svh"

module backend_tb;

	import backend_pkg::*;

	localparam int KIND_UOP = 0;
	localparam int KIND_FLUSH = 1;
	localparam int KIND_DRAIN = 2;
	localparam int ACCEPT_LIMIT = 60;
	localparam int DRAIN_LIMIT = 120;

	logic clk;
	logic rst_n;
	logic flush;
	logic uop_valid;
	uop_t uop;
	logic uop_ready;
	logic commit_valid;
	commit_t commit;

	integer seed;
	int errors;
	int timeouts;
	int commits;

	// stimulus table
	string step_name[$];
	uop_t step_uop[$];
	int step_kind[$];

	// expected commits in program order
	commit_t exp_commit[$];
	string exp_name[$];
	xlen_t spec_regs [`BE_NUM_REGS];
	xlen_t done_regs [`BE_NUM_REGS];

	clock_gen #(.PERIOD_NS(40)) clock_inst (
		.o_clk(clk),
		.o_rst_n(rst_n)
	);

	backend_top backend_top_inst (
		.CLK(clk),
		.i_rst_n(rst_n),
		.i_flush(flush),
		.i_uop_valid(uop_valid),
		.i_uop(uop),
		.o_uop_ready(uop_ready),
		.o_commit_valid(commit_valid),
		.o_commit(commit)
	);

	function automatic xlen_t calc_result(op_e op, xlen_t a, xlen_t b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_SLL: return a << b[4:0];
			OP_SRL: return a >> b[4:0];
			default: return xlen_t'($signed(a) >>> b[4:0]);
		endcase
	endfunction

	function automatic uop_t make_uop(op_e op, int rd, int rs1, int rs2, xlen_t imm,
		bit use_imm);
		uop_t u;
		u.op = op;
		u.rd = reg_idx_t'(rd);
		u.rs1 = reg_idx_t'(rs1);
		u.rs2 = reg_idx_t'(rs2);
		u.imm = imm;
		u.use_imm = use_imm;
		return u;
	endfunction

	task automatic add_step(string name, int kind, uop_t u);
		step_name.push_back(name);
		step_kind.push_back(kind);
		step_uop.push_back(u);
	endtask

	task automatic add_imm_step(string name, op_e op, int rd, int rs1, xlen_t imm);
		add_step(name, KIND_UOP, make_uop(op, rd, rs1, 0, imm, 1'b1));
	endtask

	task automatic add_reg_step(string name, op_e op, int rd, int rs1, int rs2);
		add_step(name, KIND_UOP, make_uop(op, rd, rs1, rs2, '0, 1'b0));
	endtask

	task automatic build_table();
		logic [31:0] r;
		xlen_t imm;
		for (int i = 0; i < `BE_NUM_REGS; i++) begin
			add_imm_step($sformatf("zero_x%0d", i), OP_ADD, i, i, '0);
		end
		add_step("drain_zero", KIND_DRAIN, '0);
		// operands, x3 holds a shift amount above 31
		add_imm_step("load_x1", OP_ADD, 1, 0, 32'h1234_5678);
		add_imm_step("load_x2", OP_ADD, 2, 0, 32'h8000_00f0);
		add_imm_step("load_x3", OP_ADD, 3, 0, 32'h0000_0025);
		add_reg_step("add_r", OP_ADD, 4, 1, 2);
		add_reg_step("sub_r", OP_SUB, 5, 1, 2);
		add_reg_step("and_r", OP_AND, 6, 1, 2);
		add_reg_step("or_r", OP_OR, 7, 1, 2);
		add_reg_step("xor_r", OP_XOR, 8, 1, 2);
		add_reg_step("sll_r", OP_SLL, 9, 1, 3);
		add_reg_step("srl_r", OP_SRL, 10, 2, 3);
		add_reg_step("sra_r", OP_SRA, 11, 2, 3);
		add_imm_step("add_i", OP_ADD, 12, 1, 32'hffff_ffff);
		add_imm_step("sub_i", OP_SUB, 13, 1, 32'h0000_1000);
		add_imm_step("and_i", OP_AND, 14, 2, 32'h0f0f_0f0f);
		add_imm_step("or_i", OP_OR, 15, 1, 32'hf000_0000);
		add_imm_step("xor_i", OP_XOR, 12, 2, 32'hffff_ffff);
		add_imm_step("sll_i", OP_SLL, 13, 1, 32'h0000_003f);
		add_imm_step("srl_i", OP_SRL, 14, 2, 32'h0000_0021);
		add_imm_step("sra_i", OP_SRA, 15, 2, 32'h0000_001f);
		add_step("drain_ops", KIND_DRAIN, '0);
		// shifter result arrives after the younger ALU results
		add_imm_step("order_sra", OP_SRA, 9, 2, 32'h0000_0004);
		add_imm_step("order_add", OP_ADD, 10, 1, 32'h0000_0001);
		add_imm_step("order_xor", OP_XOR, 11, 1, 32'h0000_0003);
		add_imm_step("order_or", OP_OR, 12, 4, 32'h0000_0005);
		add_step("drain_order", KIND_DRAIN, '0);
		add_reg_step("chain_a", OP_ADD, 5, 1, 1);
		add_reg_step("chain_b", OP_ADD, 5, 5, 5);
		add_reg_step("chain_c", OP_SUB, 6, 5, 1);
		add_imm_step("chain_d", OP_SLL, 6, 6, 32'h0000_0002);
		add_reg_step("chain_x0", OP_XOR, 0, 6, 1);
		// x0 is read only after its write has retired
		add_step("drain_x0", KIND_DRAIN, '0);
		add_imm_step("chain_read_x0", OP_ADD, 7, 0, '0);
		add_reg_step("chain_e", OP_SRA, 7, 6, 6);
		add_step("drain_chain", KIND_DRAIN, '0);
		// burst cut short by a flush, then readers of the flushed targets
		add_imm_step("burst_sll", OP_SLL, 8, 1, 32'h0000_0003);
		add_imm_step("burst_srl", OP_SRL, 9, 2, 32'h0000_0007);
		add_reg_step("burst_add", OP_ADD, 10, 1, 2);
		add_reg_step("burst_sub", OP_SUB, 11, 2, 1);
		add_imm_step("burst_sra", OP_SRA, 12, 2, 32'h0000_0009);
		add_step("flush", KIND_FLUSH, '0);
		add_imm_step("after_x8", OP_ADD, 13, 8, '0);
		add_imm_step("after_x9", OP_ADD, 14, 9, '0);
		add_reg_step("after_x10", OP_OR, 15, 10, 12);
		add_step("drain_flush", KIND_DRAIN, '0);
		for (int i = 0; i < 60; i++) begin
			r = $random(seed);
			imm = $random(seed);
			add_step($sformatf("rand_%0d", i), KIND_UOP,
				make_uop(op_e'(r[2:0]), int'(r[6:3]), int'(r[10:7]), int'(r[14:11]), imm, r[15]));
		end
		add_step("drain_rand", KIND_DRAIN, '0);
	endtask

	task automatic record_expected(string name, uop_t u);
		xlen_t b;
		xlen_t d;
		b = u.use_imm ? u.imm : spec_regs[u.rs2];
		d = calc_result(u.op, spec_regs[u.rs1], b);
		exp_commit.push_back('{rd: u.rd, data: d});
		exp_name.push_back(name);
		if (u.rd != '0) begin
			spec_regs[u.rd] = d;
		end
	endtask

	// entered 2 ns after a rising edge, returns at the same point
	task automatic send_uop(string name, uop_t u);
		int waited;
		bit accepted;
		waited = 0;
		accepted = 1'b0;
		uop = u;
		uop_valid = 1'b1;
		while (!accepted && waited < ACCEPT_LIMIT) begin
			@(negedge clk);
			if (uop_ready) begin
				accepted = 1'b1;
			end else begin
				waited++;
			end
		end
		if (accepted) begin
			record_expected(name, u);
			@(posedge clk);
			#2;
		end else begin
			$display("timeout: micro-op %s was never accepted", name);
			timeouts++;
		end
		uop_valid = 1'b0;
	endtask

	task automatic apply_flush();
		flush = 1'b1;
		@(posedge clk);
		#2;
		flush = 1'b0;
		// in-flight work is gone, only observed commits remain
		exp_commit.delete();
		exp_name.delete();
		for (int i = 0; i < `BE_NUM_REGS; i++) begin
			spec_regs[i] = done_regs[i];
		end
		@(negedge clk);
		assert (!commit_valid) else begin
			$display("a commit appeared in the cycle after the flush");
			errors++;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic wait_drain(string name);
		int waited;
		waited = 0;
		while (exp_commit.size() > 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_commit.size() > 0) begin
			$display("timeout: %0d commits still missing at %s", exp_commit.size(), name);
			timeouts++;
		end else begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic check_reset();
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (!rst_n) begin
				assert (!uop_ready && !commit_valid) else begin
					$display("ready or commit valid was high during reset");
					errors++;
				end
			end
		end while (!rst_n && waited < 10);
		if (!rst_n) begin
			$display("timeout: reset was never released");
			timeouts++;
		end else begin
			assert (!commit_valid) else begin
				$display("commit valid was high right after reset");
				errors++;
			end
			@(posedge clk);
			#2;
		end
	endtask

	task automatic check_commit();
		commit_t exp;
		string name;
		assert (exp_commit.size() > 0) else begin
			$display("commit of rd=%0d data=%08h with no micro-op outstanding",
				commit.rd, commit.data);
			errors++;
		end
		if (exp_commit.size() > 0) begin
			exp = exp_commit.pop_front();
			name = exp_name.pop_front();
			commits++;
			assert (commit == exp) else begin
				$display("CHECK FAILED %s expected rd=%0d data=%08h actual rd=%0d data=%08h",
					name, exp.rd, exp.data, commit.rd, commit.data);
				errors++;
			end
			if (exp.rd != '0) begin
				done_regs[exp.rd] = exp.data;
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && commit_valid) begin
			check_commit();
		end
	end

	initial begin
		seed = 32'h9f9c1ad1;
		errors = 0;
		timeouts = 0;
		commits = 0;
		flush = 1'b0;
		uop_valid = 1'b0;
		uop = '0;
		for (int i = 0; i < `BE_NUM_REGS; i++) begin
			spec_regs[i] = '0;
			done_regs[i] = '0;
		end
		build_table();
		check_reset();
		for (int i = 0; i < step_name.size() && timeouts == 0; i++) begin
			if (step_kind[i] == KIND_FLUSH) begin
				apply_flush();
			end else if (step_kind[i] == KIND_DRAIN) begin
				wait_drain(step_name[i]);
			end else begin
				send_uop(step_name[i], step_uop[i]);
			end
		end
		$display("commits checked: %0d, check errors: %0d, timeouts: %0d",
			commits, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
// free-running clock; reset is held low from time zero through the second rising edge
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// released shortly after an edge, like the other stimulus
	initial begin
		o_rst_n = 1'b0;
		repeat (2) @(posedge o_clk);
		#2;
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== hw/backend_top.sv ====
// backend top; a micro-op accepted in the same cycle as i_flush is dropped
`timescale 1ns/1ns
`default_nettype none

`include "backend_cfg.svh"

module backend_top (
	input logic CLK,
	input logic i_rst_n,
	input logic i_flush,

	input logic i_uop_valid,
	input backend_pkg::uop_t i_uop,
	output logic o_uop_ready,

	output logic o_commit_valid,
	output backend_pkg::commit_t o_commit
);

	import backend_pkg::*;

	reg_idx_t rs1;
	reg_idx_t rs2;
	xlen_t rs1_data;
	xlen_t rs2_data;
	logic [`BE_NUM_REGS-1:0] pending;
	logic set_en;
	reg_idx_t set_rd;

	logic alu_push;
	logic shift_push;
	issue_t dispatch_issue;
	logic alu_full;
	logic shift_full;

	logic rob_alloc;
	reg_idx_t rob_rd;
	logic rob_full;
	rob_tag_t rob_tag;

	logic alu_q_valid;
	logic alu_q_pop;
	issue_t alu_q_data;
	logic shift_q_valid;
	logic shift_q_pop;
	issue_t shift_q_data;

	logic alu_res_valid;
	result_t alu_res;
	logic alu_grant;
	logic shift_res_valid;
	result_t shift_res;
	logic shift_grant;

	logic wb_valid;
	result_t wb;
	logic clr_en;
	reg_idx_t clr_rd;

	arch_regfile regfile_inst (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_flush(i_flush),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.o_pending(pending),
		.i_set_en(set_en),
		.i_set_rd(set_rd),
		.i_wr_en(o_commit_valid),
		.i_wr_rd(clr_rd),
		.i_wr_data(o_commit.data),
		.i_clr_en(clr_en)
	);

	dispatch dispatch_inst (
		.i_uop_valid(i_uop_valid),
		.i_uop(i_uop),
		.o_uop_ready(o_uop_ready),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.i_pending(pending),
		.o_alu_push(alu_push),
		.o_shift_push(shift_push),
		.o_issue(dispatch_issue),
		.i_alu_full(alu_full),
		.i_shift_full(shift_full),
		.o_rob_alloc(rob_alloc),
		.o_rob_rd(rob_rd),
		.i_rob_full(rob_full),
		.i_rob_tag(rob_tag),
		.o_set_en(set_en),
		.o_set_rd(set_rd)
	);

	issue_queue #(.payload_t(issue_t)) alu_queue (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_flush(i_flush),
		.i_push(alu_push),
		.i_data(dispatch_issue),
		.o_full(alu_full),
		.i_pop(alu_q_pop),
		.o_data(alu_q_data),
		.o_valid(alu_q_valid)
	);

	issue_queue #(.payload_t(issue_t)) shift_queue (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_flush(i_flush),
		.i_push(shift_push),
		.i_data(dispatch_issue),
		.o_full(shift_full),
		.i_pop(shift_q_pop),
		.o_data(shift_q_data),
		.o_valid(shift_q_valid)
	);

	alu_unit alu_inst (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_flush(i_flush),
		.i_valid(alu_q_valid),
		.i_issue(alu_q_data),
		.o_pop(alu_q_pop),
		.o_res_valid(alu_res_valid),
		.o_res(alu_res),
		.i_grant(alu_grant)
	);

	shift_unit shift_inst (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_flush(i_flush),
		.i_valid(shift_q_valid),
		.i_issue(shift_q_data),
		.o_pop(shift_q_pop),
		.o_res_valid(shift_res_valid),
		.o_res(shift_res),
		.i_grant(shift_grant)
	);

	writeback_arbiter arbiter_inst (
		.i_alu_valid(alu_res_valid),
		.i_alu_res(alu_res),
		.i_shift_valid(shift_res_valid),
		.i_shift_res(shift_res),
		.o_alu_grant(alu_grant),
		.o_shift_grant(shift_grant),
		.o_wb_valid(wb_valid),
		.o_wb(wb)
	);

	reorder_buffer rob_inst (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_flush(i_flush),
		.i_alloc(rob_alloc),
		.i_rd(rob_rd),
		.o_full(rob_full),
		.o_tag(rob_tag),
		.i_wb_valid(wb_valid),
		.i_wb(wb),
		.o_commit_valid(o_commit_valid),
		.o_commit(o_commit),
		.o_clr_en(clr_en),
		.o_clr_rd(clr_rd)
	);

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
// in-order retire ring; full is registered and held high through reset so dispatch waits
`timescale 1ns/1ns
`default_nettype none

`include "backend_cfg.svh"

module reorder_buffer (
	input logic CLK,
	input logic i_rst_n,
	input logic i_flush,

	input logic i_alloc,
	input backend_pkg::reg_idx_t i_rd,
	output logic o_full,
	output backend_pkg::rob_tag_t o_tag,

	input logic i_wb_valid,
	input backend_pkg::result_t i_wb,

	output logic o_commit_valid,
	output backend_pkg::commit_t o_commit,
	output logic o_clr_en,
	output backend_pkg::reg_idx_t o_clr_rd
);

	import backend_pkg::*;

	localparam int DEPTH = `BE_ROB_DEPTH;
	localparam logic [ROB_TAG_W:0] PTR_ONE = 1;

	logic [ROB_TAG_W:0] head_q;
	logic [ROB_TAG_W:0] tail_q;
	logic [ROB_TAG_W:0] used_nxt;
	rob_tag_t head_idx;
	rob_tag_t tail_idx;
	logic [DEPTH-1:0] busy_q;
	logic [DEPTH-1:0] done_q;
	reg_idx_t rd_q [DEPTH];
	xlen_t data_q [DEPTH];
	logic full_q;
	logic commit_en;
	logic younger_match;

	assign head_idx = head_q[ROB_TAG_W-1:0];
	assign tail_idx = tail_q[ROB_TAG_W-1:0];
	assign commit_en = busy_q[head_idx] && done_q[head_idx];

	assign o_full = full_q;
	assign o_tag = tail_idx;
	assign o_commit_valid = commit_en;
	assign o_commit = '{rd: rd_q[head_idx], data: data_q[head_idx]};
	assign o_clr_rd = rd_q[head_idx];
	// a younger writer of the same rd keeps its scoreboard bit
	assign o_clr_en = commit_en && !younger_match;

	always_comb begin
		younger_match = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (busy_q[i] && (rob_tag_t'(i) != head_idx) && (rd_q[i] == rd_q[head_idx])) begin
				younger_match = 1'b1;
			end
		end
	end

	always_comb begin
		used_nxt = tail_q - head_q;
		if (i_alloc) begin
			used_nxt = used_nxt + PTR_ONE;
		end
		if (commit_en) begin
			used_nxt = used_nxt - PTR_ONE;
		end
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n || i_flush) begin
			head_q <= '0;
			tail_q <= '0;
			busy_q <= '0;
			done_q <= '0;
		end else begin
			if (i_alloc) begin
				busy_q[tail_idx] <= 1'b1;
				done_q[tail_idx] <= 1'b0;
				tail_q <= tail_q + PTR_ONE;
			end
			if (i_wb_valid) begin
				done_q[i_wb.rob_tag] <= 1'b1;
			end
			if (commit_en) begin
				busy_q[head_idx] <= 1'b0;
				head_q <= head_q + PTR_ONE;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			full_q <= 1'b1;
		end else if (i_flush) begin
			full_q <= 1'b0;
		end else begin
			full_q <= (used_nxt == (ROB_TAG_W+1)'(DEPTH));
		end
	end

	always_ff @(posedge CLK) begin
		if (i_alloc) begin
			rd_q[tail_idx] <= i_rd;
		end
		if (i_wb_valid) begin
			data_q[i_wb.rob_tag] <= i_wb.data;
		end
	end

	wb_targets_busy: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_wb_valid |-> busy_q[i_wb.rob_tag]);

endmodule

`default_nettype wire

// ==== hw/writeback_arbiter.sv ====
// fixed priority for the single ROB result port; a steady shifter stream starves the ALU
`timescale 1ns/1ns
`default_nettype none

module writeback_arbiter (
	input logic i_alu_valid,
	input backend_pkg::result_t i_alu_res,
	input logic i_shift_valid,
	input backend_pkg::result_t i_shift_res,

	output logic o_alu_grant,
	output logic o_shift_grant,

	output logic o_wb_valid,
	output backend_pkg::result_t o_wb
);

	// shifter wins, its result has been in flight longer
	assign o_shift_grant = i_shift_valid;
	assign o_alu_grant = i_alu_valid && !i_shift_valid;

	assign o_wb_valid = i_shift_valid || i_alu_valid;
	assign o_wb = i_shift_valid ? i_shift_res : i_alu_res;

endmodule

`default_nettype wire

// ==== hw/shift_unit.sv ====
// two-stage shifter, shift amount is the low bits of b; a stalled result freezes both stages
`timescale 1ns/1ns
`default_nettype none

module shift_unit (
	input logic CLK,
	input logic i_rst_n,
	input logic i_flush,

	input logic i_valid,
	input backend_pkg::issue_t i_issue,
	output logic o_pop,

	output logic o_res_valid,
	output backend_pkg::result_t o_res,
	input logic i_grant
);

	import backend_pkg::*;

	logic advance;
	logic s1_valid_q;
	logic s2_valid_q;
	op_e s1_op_q;
	xlen_t s1_a_q;
	logic [SHAMT_W-1:0] s1_shamt_q;
	rob_tag_t s1_tag_q;
	result_t s2_res_q;
	xlen_t shift_out;

	assign advance = !s2_valid_q || i_grant;
	assign o_pop = i_valid && advance;
	assign o_res_valid = s2_valid_q;
	assign o_res = s2_res_q;

	always_comb begin
		case (s1_op_q)
			OP_SLL: shift_out = s1_a_q << s1_shamt_q;
			OP_SRL: shift_out = s1_a_q >> s1_shamt_q;
			// sign fill
			OP_SRA: shift_out = xlen_t'($signed(s1_a_q) >>> s1_shamt_q);
			default: shift_out = s1_a_q;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n || i_flush) begin
			s1_valid_q <= 1'b0;
			s2_valid_q <= 1'b0;
		end else if (advance) begin
			s1_valid_q <= o_pop;
			s2_valid_q <= s1_valid_q;
		end
	end

	always_ff @(posedge CLK) begin
		if (advance) begin
			if (o_pop) begin
				s1_op_q <= i_issue.op;
				s1_a_q <= i_issue.a;
				s1_shamt_q <= i_issue.b[SHAMT_W-1:0];
				s1_tag_q <= i_issue.rob_tag;
			end
			s2_res_q <= '{rob_tag: s1_tag_q, data: shift_out};
		end
	end

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
// single-cycle ALU; shift opcodes are never routed here and produce zero
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
	input logic CLK,
	input logic i_rst_n,
	input logic i_flush,

	input logic i_valid,
	input backend_pkg::issue_t i_issue,
	output logic o_pop,

	output logic o_res_valid,
	output backend_pkg::result_t o_res,
	input logic i_grant
);

	import backend_pkg::*;

	logic valid_q;
	result_t res_q;
	xlen_t alu_out;

	// take a new op when the holding register empties this cycle
	assign o_pop = i_valid && (!valid_q || i_grant);
	assign o_res_valid = valid_q;
	assign o_res = res_q;

	always_comb begin
		case (i_issue.op)
			OP_ADD: alu_out = i_issue.a + i_issue.b;
			OP_SUB: alu_out = i_issue.a - i_issue.b;
			OP_AND: alu_out = i_issue.a & i_issue.b;
			OP_OR: alu_out = i_issue.a | i_issue.b;
			OP_XOR: alu_out = i_issue.a ^ i_issue.b;
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n || i_flush) begin
			valid_q <= 1'b0;
		end else if (o_pop) begin
			valid_q <= 1'b1;
		end else if (i_grant) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (o_pop) begin
			res_q <= '{rob_tag: i_issue.rob_tag, data: alu_out};
		end
	end

endmodule

`default_nettype wire

// ==== hw/issue_queue.sv ====
// in-order issue FIFO, no bypass, so a pushed entry is visible at the head one cycle later
`timescale 1ns/1ns
`default_nettype none

`include "backend_cfg.svh"

module issue_queue #(
	parameter type payload_t = logic
) (
	input logic CLK,
	input logic i_rst_n,
	input logic i_flush,

	input logic i_push,
	input payload_t i_data,
	output logic o_full,

	input logic i_pop,
	output payload_t o_data,
	output logic o_valid
);

	localparam int DEPTH = `BE_IQ_DEPTH;
	localparam int AW = $clog2(DEPTH);

	payload_t mem_q [DEPTH];
	logic [AW:0] wr_ptr_q;
	logic [AW:0] rd_ptr_q;

	// extra pointer bit tells full from empty
	assign o_full = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
		(wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
	assign o_valid = (wr_ptr_q != rd_ptr_q);
	assign o_data = mem_q[rd_ptr_q[AW-1:0]];

	always_ff @(posedge CLK) begin
		if (!i_rst_n || i_flush) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (i_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (i_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (i_push) begin
			mem_q[wr_ptr_q[AW-1:0]] <= i_data;
		end
	end

	no_push_full: assert property (@(posedge CLK) disable iff (!i_rst_n) !(i_push && o_full));
	no_pop_empty: assert property (@(posedge CLK) disable iff (!i_rst_n) !(i_pop && !o_valid));

endmodule

`default_nettype wire

// ==== hw/dispatch.sv ====
// combinational dispatch; stalls on any pending source since there is no forwarding path
`timescale 1ns/1ns
`default_nettype none

`include "backend_cfg.svh"

module dispatch (
	input logic i_uop_valid,
	input backend_pkg::uop_t i_uop,
	output logic o_uop_ready,

	output backend_pkg::reg_idx_t o_rs1,
	output backend_pkg::reg_idx_t o_rs2,
	input backend_pkg::xlen_t i_rs1_data,
	input backend_pkg::xlen_t i_rs2_data,
	input logic [`BE_NUM_REGS-1:0] i_pending,

	output logic o_alu_push,
	output logic o_shift_push,
	output backend_pkg::issue_t o_issue,
	input logic i_alu_full,
	input logic i_shift_full,

	output logic o_rob_alloc,
	output backend_pkg::reg_idx_t o_rob_rd,
	input logic i_rob_full,
	input backend_pkg::rob_tag_t i_rob_tag,

	output logic o_set_en,
	output backend_pkg::reg_idx_t o_set_rd
);

	import backend_pkg::*;

	logic is_shift;
	logic hazard;
	logic target_full;
	logic fire;

	assign is_shift = (i_uop.op == OP_SLL) || (i_uop.op == OP_SRL) || (i_uop.op == OP_SRA);

	// rs2 is ignored when the immediate replaces it
	assign hazard = i_pending[i_uop.rs1] || (!i_uop.use_imm && i_pending[i_uop.rs2]);
	assign target_full = is_shift ? i_shift_full : i_alu_full;

	assign o_uop_ready = !target_full && !i_rob_full && !hazard;
	assign fire = i_uop_valid && o_uop_ready;

	assign o_rs1 = i_uop.rs1;
	assign o_rs2 = i_uop.rs2;

	assign o_alu_push = fire && !is_shift;
	assign o_shift_push = fire && is_shift;
	assign o_issue = '{
		op: i_uop.op,
		a: i_rs1_data,
		b: i_uop.use_imm ? i_uop.imm : i_rs2_data,
		rob_tag: i_rob_tag
	};

	assign o_rob_alloc = fire;
	assign o_rob_rd = i_uop.rd;
	assign o_set_en = fire;
	assign o_set_rd = i_uop.rd;

endmodule

`default_nettype wire

// ==== hw/arch_regfile.sv ====
// committed register state and scoreboard; no bypass, a read sees only values written at commit
`timescale 1ns/1ns
`default_nettype none

`include "backend_cfg.svh"

module arch_regfile (
	input logic CLK,
	input logic i_rst_n,
	input logic i_flush,

	input backend_pkg::reg_idx_t i_rs1,
	input backend_pkg::reg_idx_t i_rs2,
	output backend_pkg::xlen_t o_rs1_data,
	output backend_pkg::xlen_t o_rs2_data,
	output logic [`BE_NUM_REGS-1:0] o_pending,

	input logic i_set_en,
	input backend_pkg::reg_idx_t i_set_rd,

	input logic i_wr_en,
	input backend_pkg::reg_idx_t i_wr_rd,
	input backend_pkg::xlen_t i_wr_data,
	input logic i_clr_en
);

	import backend_pkg::*;

	xlen_t regs_q [`BE_NUM_REGS];
	logic [`BE_NUM_REGS-1:0] pending_q;

	// x0 is never written so it stays at its reset value
	assign o_rs1_data = regs_q[i_rs1];
	assign o_rs2_data = regs_q[i_rs2];
	assign o_pending = pending_q;

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `BE_NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (i_wr_en && (i_wr_rd != '0)) begin
			regs_q[i_wr_rd] <= i_wr_data;
		end
	end

	// set after clear so a same-cycle redispatch keeps the bit
	always_ff @(posedge CLK) begin
		if (!i_rst_n || i_flush) begin
			pending_q <= '0;
		end else begin
			if (i_clr_en) begin
				pending_q[i_wr_rd] <= 1'b0;
			end
			if (i_set_en && (i_set_rd != '0)) begin
				pending_q[i_set_rd] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/backend_pkg.sv ====
// shared backend types; opcode encoding is internal and has no RISC-V funct mapping
`default_nettype none

`include "backend_cfg.svh"

package backend_pkg;

	localparam int REG_AW = $clog2(`BE_NUM_REGS);
	localparam int ROB_TAG_W = $clog2(`BE_ROB_DEPTH);
	localparam int SHAMT_W = $clog2(`BE_XLEN);

	typedef logic [`BE_XLEN-1:0] xlen_t;
	typedef logic [REG_AW-1:0] reg_idx_t;
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_SRA
	} op_e;

	// decoded micro-op from the front end
	typedef struct packed {
		op_e op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		xlen_t imm;
		logic use_imm;
	} uop_t;

	typedef struct packed {
		op_e op;
		xlen_t a;
		xlen_t b;
		rob_tag_t rob_tag;
	} issue_t;

	typedef struct packed {
		rob_tag_t rob_tag;
		xlen_t data;
	} result_t;

	typedef struct packed {
		reg_idx_t rd;
		xlen_t data;
	} commit_t;

endpackage

`default_nettype wire

// ==== hw/backend_cfg.svh ====
// sizing for the backend; both queue depths and the reorder buffer depth must be powers of two
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// architectural registers, x0 hardwired to zero
`define BE_NUM_REGS 16
`define BE_XLEN 32

// per-unit issue queue entries
`define BE_IQ_DEPTH 4

// in-flight micro-ops between dispatch and commit
`define BE_ROB_DEPTH 8

`endif
